// File: all.f
common/mipsIsaPkg.sv
common/cpuCtrlPkg.sv
source/alu.sv
source/regFile.sv
controlUnit/aluDecoder.sv
controlUnit/controlUnit.sv
source/datapath.sv
source/mipsCore.sv
test/mipsCoreTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP := mipsCoreTb
FILELIST := all.f
VFLAGS := --binary --assert --timescale 1ns/1ps -j 0 --top-module $(TOP)
OBJDIR := obj_dir
SIM := $(OBJDIR)/V$(TOP)
LOG := sim.log
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: test/mipsCoreTb.sv
module mipsCoreTb;
	timeunit 1ns;
	timeprecision 1ps;

	import mipsIsaPkg::*;

	localparam logic [31:0] resetPc = 32'h0000_0100;
	localparam int memWords = 1024;
	localparam int resetCycles = 10;
	localparam int storeTimeout = 200;

	// Register numbers used by the programs
	localparam logic [4:0] r0 = 5'd0;
	localparam logic [4:0] r1 = 5'd1;
	localparam logic [4:0] r2 = 5'd2;
	localparam logic [4:0] r3 = 5'd3;

	logic cclk;
	logic rstb;
	logic [31:0] memRdata;
	logic [31:0] memAddr;
	logic [31:0] memWdata;
	logic memWrite;

	// Memory seen by the core and the image loaded into it during reset
	logic [31:0] mem [memWords];
	logic [31:0] image [memWords];
	logic [31:0] asmAddr;
	logic [31:0] skippedAddr;
	int seed = 42842;
	int errCount = 0;
	int checkCount = 0;

	mipsCore #(
		.resetPc(resetPc)
	) i_dut (
		.cclk(cclk),
		.rstb(rstb),
		.memRdata(memRdata),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.memWrite(memWrite)
	);

	initial cclk = 1'b0;
	always #50 cclk = ~cclk;

	// Image is read while the core is held in reset
	assign memRdata = (rstb === 1'b1) ? mem[memAddr[11:2]] : image[memAddr[11:2]];

	// Image copied in during reset
	// Stores land at the rising edge
	always @(posedge cclk) begin
		if (rstb !== 1'b1) begin
			mem <= image;
		end else if (memWrite === 1'b1) begin
			mem[memAddr[11:2]] <= memWdata;
		end
	end

	// Skipped store must never show up on the port
	always @(negedge cclk) begin
		if (rstb === 1'b1 && memWrite === 1'b1) begin
			assert (memAddr !== skippedAddr) else begin
				errCount++;
				$display("store reached the skipped address %h", memAddr);
			end
		end
	end

	function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input functT fn);
		return {opRtype, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] iType(input opcodeT op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Word index of the target with the upper PC bits implied
	function automatic logic [31:0] jType(input logic [31:0] target);
		return {opJ, target[27:2]};
	endfunction

	function automatic logic [31:0] signExtend(input logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	function automatic logic [31:0] zeroExtend(input logic [15:0] imm);
		return {16'h0000, imm};
	endfunction

	function automatic logic [15:0] randomHalf();
		logic [31:0] r;
		r = $random(seed);
		return r[15:0];
	endfunction

	// Fill pattern follows the byte address and the program starts at the reset PC
	task automatic clearImage();
		int i;
		for (i = 0; i < memWords; i++) begin
			image[i] = 32'hA5A5_0000 ^ (32'(i) << 2);
		end
		asmAddr = resetPc;
	endtask

	task automatic emit(input logic [31:0] word);
		image[asmAddr[11:2]] = word;
		asmAddr = asmAddr + 32'd4;
	endtask

	// Jump to itself
	task automatic emitHalt();
		emit(jType(asmAddr));
	endtask

	task automatic assertReset();
		@(posedge cclk);
		#1 rstb = 1'b0;
	endtask

	task automatic releaseReset();
		repeat (resetCycles) @(posedge cclk);
		#1 rstb = 1'b1;
	endtask

	// Sampled mid-cycle where the store strobe is settled
	task automatic expectStore(input logic [31:0] addr, input logic [31:0] exp);
		int cycles;
		bit found;
		cycles = 0;
		found = 1'b0;
		while (!found && cycles < storeTimeout) begin
			@(negedge cclk);
			cycles++;
			if (memWrite === 1'b1 && memAddr === addr) begin
				found = 1'b1;
			end
		end
		checkCount++;
		assert (found) else begin
			errCount++;
			$display("timeout waiting for store at %h", addr);
		end
		if (found) begin
			assert (memWdata === exp) else begin
				errCount++;
				$display("[ERROR] memWdata exp=%h got=%h at %h", exp, memWdata, addr);
			end
		end
	endtask

	task automatic rtypeArithmetic();
		logic [15:0] immA;
		logic [15:0] immB;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] expV [6];
		functT fns [6];
		int k;
		assertReset();
		clearImage();
		immA = randomHalf();
		immB = randomHalf();
		a = signExtend(immA);
		b = signExtend(immB);
		fns = '{fnAdd, fnSub, fnAnd, fnOr, fnXor, fnSlt};
		expV[0] = a + b;
		expV[1] = a - b;
		expV[2] = a & b;
		expV[3] = a | b;
		expV[4] = a ^ b;
		expV[5] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		emit(iType(opAddi, r0, r1, immA));
		emit(iType(opAddi, r0, r2, immB));
		// One result register stored after every op
		for (k = 0; k < 6; k++) begin
			emit(rType(r1, r2, r3, fns[k]));
			emit(iType(opSw, r0, r3, 16'h0200 + 16'(k * 4)));
		end
		emitHalt();
		releaseReset();
		for (k = 0; k < 6; k++) begin
			expectStore(32'h0000_0200 + 32'(k * 4), expV[k]);
		end
	endtask

	task automatic immediateForms();
		logic [15:0] immA;
		logic [15:0] immB;
		logic [15:0] immN;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] expV [6];
		int k;
		assertReset();
		clearImage();
		// Signs picked so the upper half exposes a wrong extension in andi and ori
		immA = randomHalf() & 16'h7FFF;
		immB = randomHalf() | 16'h8000;
		// Top bit set so both extensions differ
		immN = randomHalf() | 16'h8000;
		a = signExtend(immA);
		b = signExtend(immB);
		expV[0] = a;
		expV[1] = ($signed(a) < $signed(signExtend(immN))) ? 32'd1 : 32'd0;
		expV[2] = b & zeroExtend(immN);
		expV[3] = a | zeroExtend(immN);
		expV[4] = a ^ zeroExtend(immN);
		expV[5] = a + signExtend(immN);
		emit(iType(opAddi, r0, r1, immA));
		emit(iType(opAddi, r0, 5'd7, immB));
		emit(iType(opSlti, r1, 5'd2, immN));
		emit(iType(opAndi, 5'd7, 5'd3, immN));
		emit(iType(opOri, r1, 5'd4, immN));
		emit(iType(opXori, r1, 5'd5, immN));
		emit(iType(opAddi, r1, 5'd6, immN));
		// r1 through r6 in order
		for (k = 0; k < 6; k++) begin
			emit(iType(opSw, r0, 5'(k + 1), 16'h0210 + 16'(k * 4)));
		end
		emitHalt();
		releaseReset();
		for (k = 0; k < 6; k++) begin
			expectStore(32'h0000_0210 + 32'(k * 4), expV[k]);
		end
	endtask

	task automatic loadStoreRoundTrip();
		logic [31:0] word;
		assertReset();
		clearImage();
		word = $random(seed);
		image[32'h300 >> 2] = word;
		emit(iType(opLw, r0, r1, 16'h0300));
		emit(iType(opSw, r0, r1, 16'h0304));
		emit(iType(opLw, r0, r2, 16'h0304));
		emit(iType(opSw, r0, r2, 16'h0308));
		emitHalt();
		releaseReset();
		expectStore(32'h0000_0304, word);
		expectStore(32'h0000_0308, word);
	endtask

	// Fall-through path marks 0x11 and the branch target marks 0x22
	task automatic branchCase(input bit isBne, input bit equal, input logic [31:0] addr);
		logic [15:0] v1;
		logic [15:0] v2;
		bit taken;
		assertReset();
		clearImage();
		v1 = randomHalf();
		v2 = equal ? v1 : (v1 ^ 16'h0001);
		taken = isBne ? !equal : equal;
		emit(iType(opAddi, r0, r1, v1));
		emit(iType(opAddi, r0, r2, v2));
		// Offset two words past the delay-free next PC
		emit(iType(isBne ? opBne : opBeq, r1, r2, 16'h0002));
		emit(iType(opAddi, r0, r3, 16'h0011));
		emit(jType(asmAddr + 32'd8));
		emit(iType(opAddi, r0, r3, 16'h0022));
		emit(iType(opSw, r0, r3, addr[15:0]));
		emitHalt();
		releaseReset();
		expectStore(addr, taken ? 32'h0000_0022 : 32'h0000_0011);
	endtask

	task automatic jumpOverStore();
		assertReset();
		clearImage();
		skippedAddr = 32'h0000_0244;
		emit(iType(opAddi, r0, r1, 16'h005A));
		emit(iType(opAddi, r0, r2, 16'h007E));
		emit(jType(asmAddr + 32'd8));
		// Never executed
		emit(iType(opSw, r0, r2, 16'h0244));
		emit(iType(opSw, r0, r1, 16'h0240));
		emitHalt();
		releaseReset();
		expectStore(32'h0000_0240, 32'h0000_005A);
		skippedAddr = '1;
	endtask

	task automatic zeroRegister();
		assertReset();
		clearImage();
		emit(iType(opAddi, r0, r0, randomHalf() | 16'h0001));
		emit(iType(opSw, r0, r0, 16'h0250));
		emitHalt();
		releaseReset();
		expectStore(32'h0000_0250, 32'h0000_0000);
	endtask

	initial begin
		rstb = 1'b0;
		skippedAddr = '1;
		clearImage();
		rtypeArithmetic();
		immediateForms();
		loadStoreRoundTrip();
		// beq taken, beq not taken, bne taken, bne not taken
		branchCase(1'b0, 1'b1, 32'h0000_0230);
		branchCase(1'b0, 1'b0, 32'h0000_0234);
		branchCase(1'b1, 1'b0, 32'h0000_0238);
		branchCase(1'b1, 1'b1, 32'h0000_023C);
		jumpOverStore();
		zeroRegister();
		$display("checks %0d, errors %0d", checkCount, errCount);
		if (errCount == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: source/mipsCore.sv
module mipsCore #(
	parameter logic [31:0] resetPc = 32'h0
) (
	input logic cclk,
	input logic rstb,
	input logic [31:0] memRdata,
	output logic [31:0] memAddr,
	output logic [31:0] memWdata,
	output logic memWrite
);
	import cpuCtrlPkg::*;

	logic [31:0] instr;
	logic memtoReg;
	logic iorD;
	logic regDst;
	pcSrcT pcSrc;
	logic aluSrcA;
	srcBSelT aluSrcB;
	logic [1:0] branch;
	logic irWrite;
	logic pcWrite;
	logic regWrite;
	logic extOp;
	aluCtrlT aluControl;

	// Sequencer, store strobe goes straight to the port
	controlUnit i_controlUnit (
		.cclk(cclk),
		.rstb(rstb),
		.Instr(instr),
		.MemtoReg(memtoReg),
		.IorD(iorD),
		.RegDst(regDst),
		.PCSrc(pcSrc),
		.ALUSrcA(aluSrcA),
		.ALUSrcB(aluSrcB),
		.Branch(branch),
		.IRWrite(irWrite),
		.MemWrite(memWrite),
		.PCWrite(pcWrite),
		.RegWrite(regWrite),
		.ExtOp(extOp),
		.ALUControl(aluControl)
	);

	datapath #(
		.resetPc(resetPc)
	) i_datapath (
		.cclk(cclk),
		.rstb(rstb),
		.MemtoReg(memtoReg),
		.IorD(iorD),
		.RegDst(regDst),
		.PCSrc(pcSrc),
		.ALUSrcA(aluSrcA),
		.ALUSrcB(aluSrcB),
		.Branch(branch),
		.IRWrite(irWrite),
		.PCWrite(pcWrite),
		.RegWrite(regWrite),
		.ExtOp(extOp),
		.ALUControl(aluControl),
		.memRdata(memRdata),
		.Instr(instr),
		.memAddr(memAddr),
		.memWdata(memWdata)
	);

endmodule

// File: source/datapath.sv
module datapath #(
	parameter logic [31:0] resetPc = 32'h0
) (
	input logic cclk,
	input logic rstb,
	input logic MemtoReg,
	input logic IorD,
	input logic RegDst,
	input cpuCtrlPkg::pcSrcT PCSrc,
	input logic ALUSrcA,
	input cpuCtrlPkg::srcBSelT ALUSrcB,
	input logic [1:0] Branch,
	input logic IRWrite,
	input logic PCWrite,
	input logic RegWrite,
	input logic ExtOp,
	input cpuCtrlPkg::aluCtrlT ALUControl,
	input logic [31:0] memRdata,
	output logic [31:0] Instr,
	output logic [31:0] memAddr,
	output logic [31:0] memWdata
);
	import cpuCtrlPkg::*;
	import mipsIsaPkg::*;

	logic [31:0] pc;
	logic [31:0] ir;
	logic [31:0] mdr;
	logic [31:0] regA;
	logic [31:0] regB;
	logic [31:0] aluOut;
	logic [31:0] rd1;
	logic [31:0] rd2;
	logic [31:0] extImm;
	logic [31:0] srcA;
	logic [31:0] srcB;
	logic [31:0] aluResult;
	logic [31:0] pcNext;
	logic [31:0] jumpTarget;
	logic [regAddrW-1:0] writeAddr;
	logic [31:0] writeData;
	logic zero;
	logic branchTaken;
	logic pcEn;

	// PC, the only reset register here
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			pc <= resetPc;
		end else if (pcEn) begin
			pc <= pcNext;
		end
	end

	// Instruction register
	always_ff @(posedge cclk) begin
		if (IRWrite) begin
			ir <= memRdata;
		end
	end

	// Data, operand and ALU result registers load every cycle
	always_ff @(posedge cclk) begin
		mdr <= memRdata;
		regA <= rd1;
		regB <= rd2;
		aluOut <= aluResult;
	end

	assign Instr = ir;

	// Shared memory port
	assign memAddr = IorD ? aluOut : pc;
	assign memWdata = regB;

	// Register write side, rd for R-type else rt
	assign writeAddr = RegDst ? ir[rdLsb +: regAddrW] : ir[rtLsb +: regAddrW];
	assign writeData = MemtoReg ? mdr : aluOut;

	regFile i_regFile (
		.cclk(cclk),
		.ra1(ir[rsLsb +: regAddrW]),
		.ra2(ir[rtLsb +: regAddrW]),
		.we(RegWrite),
		.wa(writeAddr),
		.wd(writeData),
		.rd1(rd1),
		.rd2(rd2)
	);

	// Sign or zero extension
	assign extImm = ExtOp ? {{(32 - immW){ir[immW-1]}}, ir[immW-1:0]}
		: {{(32 - immW){1'b0}}, ir[immW-1:0]};

	// ALU operands
	assign srcA = ALUSrcA ? regA : pc;
	always_comb begin
		case (ALUSrcB)
			srcBReg: srcB = regB;
			srcBFour: srcB = 32'd4;
			srcBImm: srcB = extImm;
			srcBImmShift: srcB = {extImm[29:0], 2'b00};
			default: srcB = regB;
		endcase
	end

	alu i_alu (
		.a(srcA),
		.b(srcB),
		.ALUControl(ALUControl),
		.result(aluResult),
		.zero(zero)
	);

	// Upper PC bits kept, word index shifted in
	assign jumpTarget = {pc[31:28], ir[targetW-1:0], 2'b00};

	always_comb begin
		case (PCSrc)
			pcAlu: pcNext = aluResult;
			pcAluOut: pcNext = aluOut;
			pcJump: pcNext = jumpTarget;
			default: pcNext = aluResult;
		endcase
	end

	// beq on zero, bne on nonzero
	assign branchTaken = (Branch[0] && zero) || (Branch[1] && !zero);
	assign pcEn = PCWrite || branchTaken;

endmodule

// File: controlUnit/controlUnit.sv
module controlUnit (
	input logic cclk,
	input logic rstb,
	input logic [31:0] Instr,
	// Mux selects
	output logic MemtoReg,
	output logic IorD,
	output logic RegDst,
	output cpuCtrlPkg::pcSrcT PCSrc,
	output logic ALUSrcA,
	output cpuCtrlPkg::srcBSelT ALUSrcB,
	// Bit 1 bne, bit 0 beq
	output logic [1:0] Branch,
	// Register and memory enables
	output logic IRWrite,
	output logic MemWrite,
	output logic PCWrite,
	output logic RegWrite,
	output logic ExtOp,
	output cpuCtrlPkg::aluCtrlT ALUControl
);
	import cpuCtrlPkg::*;
	import mipsIsaPkg::*;

	ctrlStateT state;
	ctrlStateT nextState;
	aluOpT aluOp;
	opcodeT opcode;
	functT funct;

	assign opcode = Instr[opLsb +: 6];
	assign funct = Instr[functLsb +: 6];

	// Logical immediates take zero extension
	assign ExtOp = !(opcode inside {opAndi, opOri, opXori});

	aluDecoder i_aluDecoder (
		.ALUOp(aluOp),
		.Funct(funct),
		.Opcode(opcode),
		.ALUControl(ALUControl)
	);

	// State register
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			state <= stFetch;
		end else begin
			state <= nextState;
		end
	end

	// Sequencing, decode fans out by opcode
	always_comb begin
		nextState = stFetch;
		case (state)
			stFetch: nextState = stDecode;
			stDecode: begin
				case (opcode)
					opLw, opSw: nextState = stMemAdr;
					opRtype: nextState = stExecute;
					opBeq, opBne: nextState = stBranch;
					opAddi, opSlti, opAndi, opOri, opXori: nextState = stItypeExecute;
					opJ: nextState = stJump;
					// Unsupported opcode, refetch
					default: nextState = stFetch;
				endcase
			end
			stMemAdr: nextState = (opcode == opLw) ? stMemRead : stMemWrite;
			stMemRead: nextState = stMemWriteback;
			stExecute: nextState = stAluWriteback;
			stItypeExecute: nextState = stItypeWriteback;
			// Writeback, store, branch and jump all end here
			default: nextState = stFetch;
		endcase
	end

	// Selects and enables per state
	always_comb begin
		MemtoReg = 1'b0;
		IorD = 1'b0;
		RegDst = 1'b0;
		PCSrc = pcAlu;
		ALUSrcA = 1'b0;
		ALUSrcB = srcBReg;
		Branch = 2'b00;
		IRWrite = 1'b0;
		MemWrite = 1'b0;
		PCWrite = 1'b0;
		RegWrite = 1'b0;
		aluOp = aopAdd;
		case (state)
			stFetch: begin
				// IR from memory at PC, PC + 4
				ALUSrcB = srcBFour;
				IRWrite = 1'b1;
				PCWrite = 1'b1;
			end
			stDecode: begin
				// Branch target into ALUOut early
				ALUSrcB = srcBImmShift;
			end
			stMemAdr: begin
				ALUSrcA = 1'b1;
				ALUSrcB = srcBImm;
			end
			stMemRead: IorD = 1'b1;
			stMemWriteback: begin
				MemtoReg = 1'b1;
				RegWrite = 1'b1;
			end
			stMemWrite: begin
				IorD = 1'b1;
				MemWrite = 1'b1;
			end
			stExecute: begin
				ALUSrcA = 1'b1;
				aluOp = aopFunct;
			end
			stAluWriteback: begin
				// rd destination
				RegDst = 1'b1;
				RegWrite = 1'b1;
			end
			stBranch: begin
				// Compare rs and rt, datapath decides
				ALUSrcA = 1'b1;
				aluOp = aopSub;
				PCSrc = pcAluOut;
				Branch = (opcode == opBne) ? 2'b10 : 2'b01;
			end
			stItypeExecute: begin
				ALUSrcA = 1'b1;
				ALUSrcB = srcBImm;
				aluOp = aopImm;
			end
			stItypeWriteback: RegWrite = 1'b1;
			stJump: begin
				PCSrc = pcJump;
				PCWrite = 1'b1;
			end
			default: ;
		endcase
	end

	// Store and register write never share a cycle
	assert property (@(posedge cclk) disable iff (!rstb) !(MemWrite && RegWrite));

	// State stays in the encoded set
	assert property (@(posedge cclk) disable iff (!rstb)
		state inside {stFetch, stDecode, stMemAdr, stMemRead, stMemWriteback, stMemWrite,
			stExecute, stAluWriteback, stBranch, stItypeExecute, stItypeWriteback, stJump});

endmodule

// File: controlUnit/aluDecoder.sv
module aluDecoder (
	input cpuCtrlPkg::aluOpT ALUOp,
	input mipsIsaPkg::functT Funct,
	input mipsIsaPkg::opcodeT Opcode,
	output cpuCtrlPkg::aluCtrlT ALUControl
);
	import cpuCtrlPkg::*;
	import mipsIsaPkg::*;

	always_comb begin
		ALUControl = aluAdd;
		case (ALUOp)
			aopAdd: ALUControl = aluAdd;
			aopSub: ALUControl = aluSub;
			// R-type by funct
			aopFunct: begin
				case (Funct)
					fnSub: ALUControl = aluSub;
					fnAnd: ALUControl = aluAnd;
					fnOr: ALUControl = aluOr;
					fnXor: ALUControl = aluXor;
					fnSlt: ALUControl = aluSlt;
					default: ALUControl = aluAdd;
				endcase
			end
			// I-type by opcode, addi falls to add
			aopImm: begin
				case (Opcode)
					opSlti: ALUControl = aluSlt;
					opAndi: ALUControl = aluAnd;
					opOri: ALUControl = aluOr;
					opXori: ALUControl = aluXor;
					default: ALUControl = aluAdd;
				endcase
			end
			default: ALUControl = aluAdd;
		endcase
	end

endmodule

// File: source/regFile.sv
module regFile (
	input logic cclk,
	input logic [4:0] ra1,
	input logic [4:0] ra2,
	input logic we,
	input logic [4:0] wa,
	input logic [31:0] wd,
	output logic [31:0] rd1,
	output logic [31:0] rd2
);

	logic [31:0] regs [32];

	// Writes to r0 dropped
	always_ff @(posedge cclk) begin
		if (we && wa != 5'd0) begin
			regs[wa] <= wd;
		end
	end

	// Combinational reads with r0 hardwired to zero
	assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1];
	assign rd2 = (ra2 == 5'd0) ? 32'd0 : regs[ra2];

endmodule

// File: source/alu.sv
module alu (
	input logic [31:0] a,
	input logic [31:0] b,
	input cpuCtrlPkg::aluCtrlT ALUControl,
	output logic [31:0] result,
	output logic zero
);
	import cpuCtrlPkg::*;

	logic lessThan;

	// Signed compare for slt
	assign lessThan = $signed(a) < $signed(b);

	always_comb begin
		case (ALUControl)
			aluAdd: result = a + b;
			aluSub: result = a - b;
			aluAnd: result = a & b;
			aluOr: result = a | b;
			aluXor: result = a ^ b;
			aluSlt: result = {31'd0, lessThan};
			default: result = 32'd0;
		endcase
	end

	// Branch compare flag
	assign zero = (result == 32'd0);

endmodule

// File: common/cpuCtrlPkg.sv
package cpuCtrlPkg;

	// Multicycle controller states
	typedef enum logic [3:0] {
		stFetch = 4'd0,
		stDecode = 4'd1,
		stMemAdr = 4'd2,
		stMemRead = 4'd3,
		stMemWriteback = 4'd4,
		stMemWrite = 4'd5,
		stExecute = 4'd6,
		stAluWriteback = 4'd7,
		stBranch = 4'd8,
		stItypeExecute = 4'd9,
		stItypeWriteback = 4'd10,
		stJump = 4'd11
	} ctrlStateT;

	// ALUOp class handed to the ALU decoder
	typedef enum logic [1:0] {
		aopAdd = 2'd0,
		aopSub = 2'd1,
		aopFunct = 2'd2,
		aopImm = 2'd3
	} aluOpT;

	// Four-bit ALU operation
	typedef enum logic [3:0] {
		aluAnd = 4'd0,
		aluOr = 4'd1,
		aluAdd = 4'd2,
		aluXor = 4'd3,
		aluSub = 4'd6,
		aluSlt = 4'd7
	} aluCtrlT;

	// Second ALU operand
	typedef enum logic [1:0] {
		srcBReg = 2'd0,
		srcBFour = 2'd1,
		srcBImm = 2'd2,
		srcBImmShift = 2'd3
	} srcBSelT;

	// Next PC source
	typedef enum logic [1:0] {
		pcAlu = 2'd0,
		pcAluOut = 2'd1,
		pcJump = 2'd2
	} pcSrcT;

endpackage

// File: common/mipsIsaPkg.sv
package mipsIsaPkg;

	// Primary opcode field
	typedef logic [5:0] opcodeT;

	// Funct field of R-type words
	typedef logic [5:0] functT;

	// Opcodes of the supported subset
	localparam opcodeT opRtype = 6'h00;
	localparam opcodeT opJ = 6'h02;
	localparam opcodeT opBeq = 6'h04;
	localparam opcodeT opBne = 6'h05;
	localparam opcodeT opAddi = 6'h08;
	localparam opcodeT opSlti = 6'h0A;
	localparam opcodeT opAndi = 6'h0C;
	localparam opcodeT opOri = 6'h0D;
	localparam opcodeT opXori = 6'h0E;
	localparam opcodeT opLw = 6'h23;
	localparam opcodeT opSw = 6'h2B;

	// R-type funct codes
	localparam functT fnAdd = 6'h20;
	localparam functT fnSub = 6'h22;
	localparam functT fnAnd = 6'h24;
	localparam functT fnOr = 6'h25;
	localparam functT fnXor = 6'h26;
	localparam functT fnSlt = 6'h2A;

	// Field positions inside the instruction word
	localparam int opLsb = 26;
	localparam int rsLsb = 21;
	localparam int rtLsb = 16;
	localparam int rdLsb = 11;
	localparam int functLsb = 0;
	localparam int regAddrW = 5;
	// Immediate and jump index widths
	localparam int immW = 16;
	localparam int targetW = 26;

endpackage
